//--- design/soc_pkg.sv
package soc_pkg;

  typedef logic [31:0] addr_t;   // byte address
  typedef logic [31:0] data_t;   // bus data word
  typedef logic [3:0]  sel_t;    // one bit per byte lane
  typedef logic [1:0]  region_t; // top two address bits

  // request from master to target
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
    sel_t  sel;
  } wb_req_t;

  // response from target to master
  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  // address map, one region per quarter of the address space
  localparam region_t REGION_RAM = 2'd0; // 0x0000_0000
  localparam region_t REGION_LED = 2'd2; // 0x8000_0000
  localparam region_t REGION_KEY = 2'd3; // 0xC000_0000

  // idle values for bus structs
  localparam wb_req_t WB_REQ_IDLE = '{
    cyc: 1'b0,
    stb: 1'b0,
    we:  1'b0,
    adr: '0,
    dat: '0,
    sel: '0
  };

  localparam wb_rsp_t WB_RSP_IDLE = '{
    ack: 1'b0,
    err: 1'b0,
    dat: '0
  };

endpackage

//--- design/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic             clk,
  input  logic             rst_i,
  input  soc_pkg::wb_req_t host_i,
  output soc_pkg::wb_rsp_t host_o,
  output soc_pkg::wb_req_t ram_o,
  input  soc_pkg::wb_rsp_t ram_i,
  output soc_pkg::wb_req_t led_o,
  input  soc_pkg::wb_rsp_t led_i,
  output soc_pkg::wb_req_t key_o,
  input  soc_pkg::wb_rsp_t key_i
);

  import soc_pkg::*;

  region_t region;
  logic    sel_ram;
  logic    sel_led;
  logic    sel_key;
  logic    sel_none;
  logic    err_q;

  assign region   = host_i.adr[31:30];
  assign sel_ram  = (region == REGION_RAM);
  assign sel_led  = (region == REGION_LED);
  assign sel_key  = (region == REGION_KEY);
  assign sel_none = ~(sel_ram | sel_led | sel_key);

  // all targets see the same request, only the selected one gets stb
  always_comb
  begin
    ram_o     = host_i;
    led_o     = host_i;
    key_o     = host_i;
    ram_o.stb = host_i.stb & sel_ram;
    led_o.stb = host_i.stb & sel_led;
    key_o.stb = host_i.stb & sel_key;
  end

  // unmapped region answers like a target would, one cycle later
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      err_q <= 1'b0;
    end
    else
    begin
      err_q <= host_i.cyc & host_i.stb & sel_none & ~err_q;
    end
  end

  // idle targets drive zeros, so a plain OR merges them
  always_comb
  begin
    host_o     = WB_RSP_IDLE;
    host_o.ack = ram_i.ack | led_i.ack | key_i.ack;
    host_o.err = ram_i.err | led_i.err | key_i.err | err_q;
    host_o.dat = ram_i.dat | led_i.dat | key_i.dat;
  end

endmodule

//--- design/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
  parameter int RAM_WORDS = 64
) (
  input  logic             clk,
  input  logic             rst_i,
  input  soc_pkg::wb_req_t bus_i,
  output soc_pkg::wb_rsp_t bus_o
);

  import soc_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);

  data_t            mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             hit;
  logic             ack_q;
  data_t            rdata_q;

  assign idx = bus_i.adr[IDX_W+1:2]; // word index, wraps at the depth
  assign hit = bus_i.cyc & bus_i.stb & ~ack_q;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= hit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (hit & bus_i.we)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (bus_i.sel[b])
        begin
          mem[idx][b*8 +: 8] <= bus_i.dat[b*8 +: 8];
        end
      end
    end
    if (hit)
    begin
      rdata_q <= mem[idx];
    end
  end

  assign bus_o.ack = ack_q;
  assign bus_o.err = 1'b0;
  assign bus_o.dat = ack_q ? rdata_q : '0; // quiet when not acking
endmodule

//--- design/led_port.sv
`timescale 1ns/1ps

module led_port #(
  parameter int LED_WIDTH = 5
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  soc_pkg::wb_req_t     bus_i,
  output soc_pkg::wb_rsp_t     bus_o,
  output logic [LED_WIDTH-1:0] pins_o
);

  import soc_pkg::*;

  logic                 hit;
  logic                 ack_q;
  logic [LED_WIDTH-1:0] led_q;

  assign hit = bus_i.cyc & bus_i.stb & ~ack_q; // whole region maps to one register

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      ack_q <= 1'b0;
      led_q <= '0;
    end
    else
    begin
      ack_q <= hit;
      if (hit & bus_i.we & bus_i.sel[0])
      begin
        led_q <= bus_i.dat[LED_WIDTH-1:0];
      end
    end
  end

  assign pins_o    = led_q;
  assign bus_o.ack = ack_q;
  assign bus_o.err = 1'b0;
  assign bus_o.dat = ack_q ? data_t'(led_q) : '0;
endmodule

//--- design/key_port.sv
`timescale 1ns/1ps

module key_port #(
  parameter int KEY_WIDTH = 2
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  soc_pkg::wb_req_t     bus_i,
  output soc_pkg::wb_rsp_t     bus_o,
  input  logic [KEY_WIDTH-1:0] pins_i
);

  import soc_pkg::*;

  logic [KEY_WIDTH-1:0] sync1_q;
  logic [KEY_WIDTH-1:0] sync2_q;
  logic [KEY_WIDTH-1:0] pressed;
  logic [KEY_WIDTH-1:0] pressed_q;
  logic [KEY_WIDTH-1:0] flags_q;
  logic [KEY_WIDTH-1:0] clr;
  logic                 hit;
  logic                 ack_q;
  data_t                rdata;

  assign pressed = ~sync2_q; // pins are active low
  assign hit     = bus_i.cyc & bus_i.stb & ~ack_q;
  assign clr     = (hit & bus_i.we & bus_i.sel[1]) ? bus_i.dat[8 +: KEY_WIDTH] : '0;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      sync1_q   <= '1; // released
      sync2_q   <= '1;
      pressed_q <= '0;
      flags_q   <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      sync1_q   <= pins_i;
      sync2_q   <= sync1_q;
      pressed_q <= pressed;
      flags_q   <= (flags_q & ~clr) | (pressed & ~pressed_q); // new press wins over clear
      ack_q     <= hit;
    end
  end

  always_comb
  begin
    rdata                    = '0;
    rdata[KEY_WIDTH-1:0]     = pressed;
    rdata[8 +: KEY_WIDTH]    = flags_q;
  end

  // read data taken at the ack edge, live level otherwise would glitch the OR
  data_t rdata_q;

  always_ff @(posedge clk)
  begin
    if (hit)
    begin
      rdata_q <= rdata;
    end
  end

  assign bus_o.ack = ack_q;
  assign bus_o.err = 1'b0;
  assign bus_o.dat = ack_q ? rdata_q : '0;
endmodule

//--- design/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
  parameter int RAM_WORDS = 64,
  parameter int LED_WIDTH = 5,
  parameter int KEY_WIDTH = 2
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  soc_pkg::wb_req_t     bus_i,
  output soc_pkg::wb_rsp_t     bus_o,
  input  logic [KEY_WIDTH-1:0] keys_i,
  output logic [LED_WIDTH-1:0] led_o
);

  import soc_pkg::*;

  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  wb_req_t led_req;
  wb_rsp_t led_rsp;
  wb_req_t key_req;
  wb_rsp_t key_rsp;

  bus_decoder u_decoder (
    .clk    (clk),
    .rst_i  (rst_i),
    .host_i (bus_i),
    .host_o (bus_o),
    .ram_o  (ram_req),
    .ram_i  (ram_rsp),
    .led_o  (led_req),
    .led_i  (led_rsp),
    .key_o  (key_req),
    .key_i  (key_rsp)
  );

  scratch_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
    .clk   (clk),
    .rst_i (rst_i),
    .bus_i (ram_req),
    .bus_o (ram_rsp)
  );

  led_port #(.LED_WIDTH(LED_WIDTH)) u_led (
    .clk    (clk),
    .rst_i  (rst_i),
    .bus_i  (led_req),
    .bus_o  (led_rsp),
    .pins_o (led_o)
  );

  key_port #(.KEY_WIDTH(KEY_WIDTH)) u_key (
    .clk    (clk),
    .rst_i  (rst_i),
    .bus_i  (key_req),
    .bus_o  (key_rsp),
    .pins_i (keys_i)
  );

endmodule

//--- verif/tb_soc_top.sv
`timescale 1ns/1ps

module tb_soc_top;

  import soc_pkg::*;

  localparam int    RAM_WORDS   = 64;
  localparam int    LED_WIDTH   = 5;
  localparam int    KEY_WIDTH   = 2;
  localparam int    BUS_TIMEOUT = 20; // cycles
  localparam string VEC_FILE    = "verif/soc_vectors.txt";

  typedef logic [8*24-1:0] name_t; // test name as read from the vectors

  logic                 clk;
  logic                 rst_i;
  wb_req_t              bus_req;
  wb_rsp_t              bus_rsp;
  logic [KEY_WIDTH-1:0] keys_i;
  logic [LED_WIDTH-1:0] led_o;

  soc_top #(
    .RAM_WORDS (RAM_WORDS),
    .LED_WIDTH (LED_WIDTH),
    .KEY_WIDTH (KEY_WIDTH)
  ) DUT (
    .clk    (clk),
    .rst_i  (rst_i),
    .bus_i  (bus_req),
    .bus_o  (bus_rsp),
    .keys_i (keys_i),
    .led_o  (led_o)
  );

  always #10 clk = ~clk;

  task automatic stop_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_data(input name_t name, input data_t exp, input data_t act);
    if (exp !== act)
    begin
      $display("FAIL %0s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_led(input name_t name, input logic [LED_WIDTH-1:0] exp,
                           input logic [LED_WIDTH-1:0] act);
    if (exp !== act)
    begin
      $display("FAIL %0s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_resp(input name_t name, input wb_rsp_t exp, input wb_rsp_t act);
    if ({exp.ack, exp.err} !== {act.ack, act.err})
    begin
      $display("FAIL %0s expected ack=%b err=%b actual ack=%b err=%b",
               name, exp.ack, exp.err, act.ack, act.err);
      stop_run();
    end
  endtask

  // one classic cycle, request held until ack or err
  task automatic bus_cycle(input name_t name, input logic we, input addr_t adr,
                           input data_t dat, input sel_t sel, output wb_rsp_t rsp);
    int waited;

    @(negedge clk);
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we  = we;
    bus_req.adr = adr;
    bus_req.dat = dat;
    bus_req.sel = sel;
    @(negedge clk);
    waited = 1;
    while (!(bus_rsp.ack || bus_rsp.err))
    begin
      if (waited >= BUS_TIMEOUT)
      begin
        $display("ERROR %0s: the bus gave neither ack nor err within %0d cycles",
                 name, BUS_TIMEOUT);
        stop_run();
      end
      @(negedge clk);
      waited++;
    end
    rsp     = bus_rsp;
    bus_req = WB_REQ_IDLE; // drop cyc and stb
  endtask

  initial
  begin
    int         fd;
    int         n_fields;
    int         n_vec;
    string      line;
    logic [7:0] op;
    logic [7:0] resp_kind;
    addr_t      adr;
    data_t      dat;
    sel_t       sel;
    data_t      exp;
    name_t      name;
    wb_rsp_t    exp_rsp;
    wb_rsp_t    rsp;

    void'($urandom(32'hc1c1_50fd));
    clk     = 1'b0;
    rst_i   = 1'b1;
    bus_req = WB_REQ_IDLE;
    keys_i  = '1; // keys released
    n_vec   = 0;
    repeat (5) @(negedge clk);
    rst_i = 1'b0;

    fd = $fopen(VEC_FILE, "r");
    if (fd == 0)
    begin
      $display("ERROR could not open the vector file %s", VEC_FILE);
      stop_run();
    end

    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line[0] == "#")
      begin
        continue; // comment or blank line
      end
      n_fields = $sscanf(line, "%s %h %h %h %h %s %s",
                         op, adr, dat, sel, exp, resp_kind, name);
      if (n_fields != 7)
      begin
        $display("ERROR malformed line in the vector file: %s", line);
        stop_run();
      end
      exp_rsp     = WB_RSP_IDLE;
      exp_rsp.ack = (resp_kind == "A");
      exp_rsp.err = (resp_kind == "E");
      case (op)
        "W":
        begin
          bus_cycle(name, 1'b1, adr, dat, sel, rsp);
          check_resp(name, exp_rsp, rsp);
        end
        "R":
        begin
          bus_cycle(name, 1'b0, adr, dat, sel, rsp);
          check_resp(name, exp_rsp, rsp);
          if (exp_rsp.ack)
          begin
            check_data(name, exp, rsp.dat);
          end
        end
        "K":
        begin
          @(negedge clk);
          keys_i = dat[KEY_WIDTH-1:0];
          repeat (5) @(negedge clk); // past the synchronizer
        end
        "L":
        begin
          @(negedge clk);
          check_led(name, exp[LED_WIDTH-1:0], led_o);
        end
        default:
        begin
          $display("ERROR unknown operation code in the vector file: %s", line);
          stop_run();
        end
      endcase
      n_vec++;
      repeat ($urandom % 4) @(negedge clk); // idle gap
    end
    $fclose(fd);

    if (n_vec == 0)
    begin
      $display("ERROR the vector file holds no operations");
      stop_run();
    end
    else
    begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- verif/soc_vectors.txt
# op addr     data     sel exp      resp name
# W write, R read (exp is read data), K key pins active low (data), L LED check (exp)
L 00000000 00000000 0 00000000 A led_reset
R c0000000 00000000 f 00000000 A key_reset
W 00000000 11223344 f 00000000 A ram_wr0
W 00000004 a5a55a5a f 00000000 A ram_wr1
W 000000fc deadbeef f 00000000 A ram_wr63
R 00000000 00000000 f 11223344 A ram_rd0
R 00000004 00000000 f a5a55a5a A ram_rd1
R 000000fc 00000000 f deadbeef A ram_rd63
W 00000104 cafef00d f 00000000 A ram_wrap_wr
R 00000004 00000000 f cafef00d A ram_wrap_rd
R 00000100 00000000 f 11223344 A ram_wrap_rd0
W 00000020 01020304 f 00000000 A ram_byte_full
W 00000020 aabbccdd 5 00000000 A ram_byte_sel5
R 00000020 00000000 f 01bb03dd A ram_byte_rd5
W 00000020 11223344 a 00000000 A ram_byte_sela
R 00000020 00000000 f 11bb33dd A ram_byte_rda
W 80000000 00000035 f 00000000 A led_wr
L 00000000 00000000 0 00000015 A led_pins
R 80000000 00000000 f 00000015 A led_rd
W 80000010 0000000a e 00000000 A led_wr_nosel
L 00000000 00000000 0 00000015 A led_pins_kept
R 80000004 00000000 f 00000015 A led_rd_kept
K 00000000 00000002 0 00000000 A key0_press
R c0000000 00000000 f 00000101 A key0_pressed
K 00000000 00000003 0 00000000 A key0_release
R c0000000 00000000 f 00000100 A key0_sticky
W c0000000 00000100 2 00000000 A key0_clear
R c0000000 00000000 f 00000000 A key0_cleared
W 40000000 0000001f f 00000000 E unmapped_wr
R 40000000 00000000 f 00000000 E unmapped_rd
R 00000000 00000000 f 11223344 A ram_after_unmap
L 00000000 00000000 0 00000015 A led_after_unmap

//--- verilog.f
design/soc_pkg.sv
design/bus_decoder.sv
design/scratch_ram.sv
design/led_port.sv
design/key_port.sv
design/soc_top.sv
verif/tb_soc_top.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timescale 1ns/1ps --top-module tb_soc_top -f verilog.f &&
  ./obj_dir/Vtb_soc_top || exit 1
